//--- pkt_switch.f
hw/pkt_switch_pkg.sv
hw/stream_fifo.sv
hw/stream_demux.sv
hw/packet_mux.sv
hw/pkt_switch.sv
verification/pkt_switch_assert.sv
verification/pkt_switch_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f pkt_switch.f \
   --top-module pkt_switch_tb -Mdir obj_dir

output=$(./obj_dir/Vpkt_switch_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "test passed"; then
   exit 0
fi
exit 1

//--- verification/pkt_switch_tb.sv
// ========================================
// Testbench for the 2x2 packet switch. Random packets on both
// inputs and random output back-pressure; bound assertions check.
// ========================================

`timescale 1ns/1ns

module pkt_switch_tb;

   logic                                 clk;
   logic                                 i_reset;
   logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::data_width-1:0] i_tdata;
   logic [pkt_switch_pkg::num_ports-1:0] i_tlast;
   logic [pkt_switch_pkg::num_ports-1:0] i_tvalid;
   logic [pkt_switch_pkg::num_ports-1:0] i_tready;
   logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::data_width-1:0] o_tdata;
   logic [pkt_switch_pkg::num_ports-1:0] o_tlast;
   logic [pkt_switch_pkg::num_ports-1:0] o_tvalid;
   logic [pkt_switch_pkg::num_ports-1:0] o_tready;

   logic [31:0] lfsr;
   int          words_left   [pkt_switch_pkg::num_ports];
   int          gap_left     [pkt_switch_pkg::num_ports];
   int          pkts_started [pkt_switch_pkg::num_ports];
   int          pkts_sent    [pkt_switch_pkg::num_ports];
   logic        cur_dest     [pkt_switch_pkg::num_ports];
   logic [pkt_switch_pkg::data_width-pkt_switch_pkg::seq_lsb-1:0]
                seq_cnt [pkt_switch_pkg::num_ports][pkt_switch_pkg::num_ports];
   int          pkts_recv;
   int          tb_errors;
   int          drain_cycles;
   int          total_errors;

   pkt_switch u_dut (.*);

   always #5 clk = ~clk;

   // galois LFSR, one step per returned bit.
   function automatic logic [3:0] rand_bits(input int n);
      logic [3:0] val;
      int         i;
      val = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         val  = {val[2:0], lfsr[0]};
      end
      return val;
   endfunction

   task automatic drive_source(input int s);
      logic [pkt_switch_pkg::data_width-1:0] word;
      begin
         if (i_tvalid[s] && i_tready[s]) begin
            seq_cnt[s][cur_dest[s]] = seq_cnt[s][cur_dest[s]] + 1'b1;
            words_left[s] = words_left[s] - 1;
            if (words_left[s] == 0) begin
               pkts_sent[s] = pkts_sent[s] + 1;
               gap_left[s]  = rand_bits(2);
            end
         end
         // a stalled word stays on the bus untouched.
         if (!(i_tvalid[s] && !i_tready[s])) begin
            if (gap_left[s] != 0) begin
               gap_left[s] = gap_left[s] - 1;
               i_tvalid[s] <= 1'b0;
            end else if (words_left[s] == 0 && pkts_started[s] == 60) begin
               i_tvalid[s] <= 1'b0;
            end else begin
               if (words_left[s] == 0) begin
                  cur_dest[s]     = (rand_bits(1) != 0);
                  words_left[s]   = rand_bits(2) + 1;
                  pkts_started[s] = pkts_started[s] + 1;
               end
               word = '0;
               word[pkt_switch_pkg::data_width-1:pkt_switch_pkg::seq_lsb] = seq_cnt[s][cur_dest[s]];
               word[pkt_switch_pkg::src_bit]  = 1'(s);
               word[pkt_switch_pkg::dest_bit] = cur_dest[s];
               i_tdata[s]  <= word;
               i_tlast[s]  <= (words_left[s] == 1);
               i_tvalid[s] <= 1'b1;
            end
         end
      end
   endtask

   task automatic count_outputs();
      int p;
      begin
         for (p = 0; p < pkt_switch_pkg::num_ports; p++) begin
            if (o_tvalid[p] && o_tready[p] && o_tlast[p]) begin
               pkts_recv = pkts_recv + 1;
            end
         end
      end
   endtask

   initial begin
      clk          = 1'b0;
      i_reset      = 1'b1;
      i_tdata      = '0;
      i_tlast      = '0;
      i_tvalid     = '0;
      o_tready     = '0;
      lfsr         = 32'h5857;
      pkts_recv    = 0;
      tb_errors    = 0;
      drain_cycles = 0;
      for (int s = 0; s < pkt_switch_pkg::num_ports; s++) begin
         words_left[s]   = 0;
         gap_left[s]     = 0;
         pkts_started[s] = 0;
         pkts_sent[s]    = 0;
         cur_dest[s]     = 1'b0;
         for (int d = 0; d < pkt_switch_pkg::num_ports; d++) begin
            seq_cnt[s][d] = '0;
         end
      end
      repeat (4) @(posedge clk);
      i_reset <= 1'b0;

      while (pkts_sent[0] < 60 || pkts_sent[1] < 60) begin
         @(posedge clk);
         count_outputs();
         drive_source(0);
         drive_source(1);
         for (int p = 0; p < pkt_switch_pkg::num_ports; p++) begin
            o_tready[p] <= (rand_bits(2) != 0);
         end
      end

      // inputs done, let both output FIFOs empty.
      i_tvalid <= '0;
      o_tready <= '1;
      while (pkts_recv < pkts_sent[0] + pkts_sent[1] && drain_cycles < 200) begin
         @(posedge clk);
         count_outputs();
         drain_cycles = drain_cycles + 1;
      end

      if (pkts_recv != pkts_sent[0] + pkts_sent[1]) begin
         tb_errors = tb_errors + 1;
         $display("packet count mismatch at %0t: sent %0d packets but received %0d",
                  $time, pkts_sent[0] + pkts_sent[1], pkts_recv);
      end

      total_errors = tb_errors + u_dut.u_assert.err_count;
      $display("errors %0d (assertions %0d, testbench %0d), packets sent %0d, received %0d",
               total_errors, u_dut.u_assert.err_count, tb_errors,
               pkts_sent[0] + pkts_sent[1], pkts_recv);
      if (total_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // 120 packets of up to 4 words, 20 cycles per word.
   initial begin
      #(120 * 4 * 20 * 10);
      $display("timeout at %0t: the switch did not deliver all packets in time", $time);
      $display("test failed");
      $finish;
   end

endmodule

//--- verification/pkt_switch_assert.sv
// ========================================
// Concurrent checks on the switch outputs, bound to the top level.
// Tracks each output's packets and per-source sequence numbers.
// ========================================

`timescale 1ns/1ns

module pkt_switch_assert (
   input logic                                 clk,
   input logic                                 i_reset,
   input logic [pkt_switch_pkg::num_ports-1:0] i_tready,
   input logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::data_width-1:0] o_tdata,
   input logic [pkt_switch_pkg::num_ports-1:0] o_tlast,
   input logic [pkt_switch_pkg::num_ports-1:0] o_tvalid,
   input logic [pkt_switch_pkg::num_ports-1:0] o_tready
);

   typedef logic [pkt_switch_pkg::data_width-pkt_switch_pkg::seq_lsb-1:0] seq_t;

   int err_count = 0;

   a_reset: assert property (@(posedge clk) i_reset |=> (o_tvalid == '0) && (i_tready == '0))
      else begin
         err_count = err_count + 1;
         $error("CHECK FAILED t=%0t o_tvalid expected 0 got %b, i_tready expected 0 got %b",
                $time, $sampled(o_tvalid), $sampled(i_tready));
      end

   for (genvar p = 0; p < pkt_switch_pkg::num_ports; p++) begin : g_port
      logic                                          xfer;
      logic                                          src;
      seq_t                                          seq;
      seq_t [pkt_switch_pkg::num_ports-1:0]          exp_seq;
      logic                                          in_pkt;
      logic                                          pkt_src;
      logic [pkt_switch_pkg::data_width-1:0]         prev_data;
      logic                                          prev_last;

      assign xfer = o_tvalid[p] & o_tready[p];
      assign src  = o_tdata[p][pkt_switch_pkg::src_bit];
      assign seq  = o_tdata[p][pkt_switch_pkg::data_width-1:pkt_switch_pkg::seq_lsb];

      // next expected sequence per source, and the source of the open packet.
      always_ff @(posedge clk) begin
         prev_data <= o_tdata[p];
         prev_last <= o_tlast[p];
         if (i_reset) begin
            exp_seq <= '0;
            in_pkt  <= 1'b0;
            pkt_src <= 1'b0;
         end else if (xfer) begin
            exp_seq[src] <= seq + 1'b1;
            in_pkt       <= ~o_tlast[p];
            pkt_src      <= src;
         end
      end

      a_route: assert property (@(posedge clk) disable iff (i_reset)
         o_tvalid[p] |-> o_tdata[p][pkt_switch_pkg::dest_bit] == 1'(p))
         else begin
            err_count = err_count + 1;
            $error("CHECK FAILED t=%0t o_tdata[%0d] dest bit expected %0d got %0d",
                   $time, p, p, $sampled(o_tdata[p][pkt_switch_pkg::dest_bit]));
         end

      a_no_interleave: assert property (@(posedge clk) disable iff (i_reset)
         xfer && in_pkt |-> src == pkt_src)
         else begin
            err_count = err_count + 1;
            $error("CHECK FAILED t=%0t o_tdata[%0d] src bit expected %0d got %0d",
                   $time, p, $sampled(pkt_src), $sampled(src));
         end

      a_flow_order: assert property (@(posedge clk) disable iff (i_reset)
         xfer |-> seq == exp_seq[src])
         else begin
            err_count = err_count + 1;
            $error("CHECK FAILED t=%0t o_tdata[%0d] sequence expected %0d got %0d",
                   $time, p, $sampled(exp_seq[src]), $sampled(seq));
         end

      a_hold_valid: assert property (@(posedge clk) disable iff (i_reset)
         o_tvalid[p] && !o_tready[p] |=> o_tvalid[p])
         else begin
            err_count = err_count + 1;
            $error("CHECK FAILED t=%0t o_tvalid[%0d] expected 1 got 0", $time, p);
         end

      a_hold_data: assert property (@(posedge clk) disable iff (i_reset)
         o_tvalid[p] && !o_tready[p] |=> o_tdata[p] == prev_data && o_tlast[p] == prev_last)
         else begin
            err_count = err_count + 1;
            $error("CHECK FAILED t=%0t o_tdata/o_tlast[%0d] expected %h/%b got %h/%b",
                   $time, p, $sampled(prev_data), $sampled(prev_last),
                   $sampled(o_tdata[p]), $sampled(o_tlast[p]));
         end
   end

endmodule

bind pkt_switch pkt_switch_assert u_assert (
   .clk      (clk),
   .i_reset  (i_reset),
   .i_tready (i_tready),
   .o_tdata  (o_tdata),
   .o_tlast  (o_tlast),
   .o_tvalid (o_tvalid),
   .o_tready (o_tready)
);

//--- hw/pkt_switch.sv
// ========================================
// Top level of the 2x2 packet switch. Each input has a demux,
// each output a round-robin mux with an output FIFO.
// ========================================

`timescale 1ns/1ns

module pkt_switch (
   input  logic                                 clk,
   input  logic                                 i_reset,
   input  logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::data_width-1:0] i_tdata,
   input  logic [pkt_switch_pkg::num_ports-1:0] i_tlast,
   input  logic [pkt_switch_pkg::num_ports-1:0] i_tvalid,
   output logic [pkt_switch_pkg::num_ports-1:0] i_tready,
   output logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::data_width-1:0] o_tdata,
   output logic [pkt_switch_pkg::num_ports-1:0] o_tlast,
   output logic [pkt_switch_pkg::num_ports-1:0] o_tvalid,
   input  logic [pkt_switch_pkg::num_ports-1:0] o_tready
);

   // lanes indexed [demux][port] on the demux side.
   logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::num_ports-1:0]
         [pkt_switch_pkg::data_width-1:0] demux_tdata;
   logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::num_ports-1:0] demux_tlast;
   logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::num_ports-1:0] demux_tvalid;
   logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::num_ports-1:0] demux_tready;

   // same lanes indexed [port][demux] on the mux side.
   logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::num_ports-1:0]
         [pkt_switch_pkg::data_width-1:0] mux_tdata;
   logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::num_ports-1:0] mux_tlast;
   logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::num_ports-1:0] mux_tvalid;
   logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::num_ports-1:0] mux_tready;

   for (genvar d = 0; d < pkt_switch_pkg::num_ports; d++) begin : g_demux
      stream_demux u_demux (
         .clk           (clk),
         .i_reset       (i_reset),
         .i_tdata       (i_tdata[d]),
         .i_tlast       (i_tlast[d]),
         .i_tvalid      (i_tvalid[d]),
         .o_tready      (i_tready[d]),
         .o_lane_tdata  (demux_tdata[d]),
         .o_lane_tlast  (demux_tlast[d]),
         .o_lane_tvalid (demux_tvalid[d]),
         .i_lane_tready (demux_tready[d])
      );
   end

   // lane (d, p) crosses from demux d to mux p.
   for (genvar d = 0; d < pkt_switch_pkg::num_ports; d++) begin : g_cross_d
      for (genvar p = 0; p < pkt_switch_pkg::num_ports; p++) begin : g_cross_p
         assign mux_tdata[p][d]    = demux_tdata[d][p];
         assign mux_tlast[p][d]    = demux_tlast[d][p];
         assign mux_tvalid[p][d]   = demux_tvalid[d][p];
         assign demux_tready[d][p] = mux_tready[p][d];
      end
   end

   for (genvar p = 0; p < pkt_switch_pkg::num_ports; p++) begin : g_mux
      packet_mux u_mux (
         .clk           (clk),
         .i_reset       (i_reset),
         .i_lane_tdata  (mux_tdata[p]),
         .i_lane_tlast  (mux_tlast[p]),
         .i_lane_tvalid (mux_tvalid[p]),
         .o_lane_tready (mux_tready[p]),
         .o_tdata       (o_tdata[p]),
         .o_tlast       (o_tlast[p]),
         .o_tvalid      (o_tvalid[p]),
         .i_tready      (o_tready[p])
      );
   end

endmodule

//--- hw/packet_mux.sv
// ========================================
// Round-robin packet multiplexer for one output port.
// Grants a whole packet at a time into the output FIFO.
// ========================================

`timescale 1ns/1ns

module packet_mux (
   input  logic                                 clk,
   input  logic                                 i_reset,
   input  logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::data_width-1:0] i_lane_tdata,
   input  logic [pkt_switch_pkg::num_ports-1:0] i_lane_tlast,
   input  logic [pkt_switch_pkg::num_ports-1:0] i_lane_tvalid,
   output logic [pkt_switch_pkg::num_ports-1:0] o_lane_tready,
   output logic [pkt_switch_pkg::data_width-1:0] o_tdata,
   output logic                                 o_tlast,
   output logic                                 o_tvalid,
   input  logic                                 i_tready
);

   logic [pkt_switch_pkg::num_ports-1:0] grant;
   logic                                 last_winner;
   logic                                 next_idx;
   logic                                 sel_idx;

   pkt_switch_pkg::stream_word_t fifo_in;
   pkt_switch_pkg::stream_word_t fifo_out;
   logic                         fifo_in_valid;
   logic                         fifo_ready;
   logic                         fifo_wr;

   // the lane that lost last time wins a tie.
   assign next_idx = i_lane_tvalid[~last_winner] ? ~last_winner : last_winner;

   assign sel_idx = grant[1];

   always_ff @(posedge clk) begin
      if (i_reset) begin
         grant       <= '0;
         last_winner <= 1'b0;
      end else if (grant == '0) begin
         if (|i_lane_tvalid) begin
            grant[next_idx] <= 1'b1;
            last_winner     <= next_idx;
         end
      end else if (fifo_wr & fifo_in.last) begin
         grant <= '0;
      end
   end

   assign fifo_in       = '{last: i_lane_tlast[sel_idx], data: i_lane_tdata[sel_idx]};
   assign fifo_in_valid = |(i_lane_tvalid & grant);
   assign fifo_wr       = fifo_in_valid & fifo_ready;

   assign o_lane_tready = grant & {pkt_switch_pkg::num_ports{fifo_ready}};

   stream_fifo #(
      .T (pkt_switch_pkg::stream_word_t)
   ) u_fifo (
      .clk     (clk),
      .i_reset (i_reset),
      .i_data  (fifo_in),
      .i_valid (fifo_in_valid),
      .o_ready (fifo_ready),
      .o_data  (fifo_out),
      .o_valid (o_tvalid),
      .i_ready (i_tready)
   );

   assign o_tdata = fifo_out.data;
   assign o_tlast = fifo_out.last;

endmodule

//--- hw/stream_demux.sv
// ========================================
// Packet demultiplexer. Routes each packet to the lane named
// by dest_bit of its header, with one bubble cycle per packet.
// ========================================

`timescale 1ns/1ns

module stream_demux (
   input  logic                                 clk,
   input  logic                                 i_reset,
   input  logic [pkt_switch_pkg::data_width-1:0] i_tdata,
   input  logic                                 i_tlast,
   input  logic                                 i_tvalid,
   output logic                                 o_tready,
   output logic [pkt_switch_pkg::num_ports-1:0][pkt_switch_pkg::data_width-1:0] o_lane_tdata,
   output logic [pkt_switch_pkg::num_ports-1:0] o_lane_tlast,
   output logic [pkt_switch_pkg::num_ports-1:0] o_lane_tvalid,
   input  logic [pkt_switch_pkg::num_ports-1:0] i_lane_tready
);

   // one-hot select, all zero while waiting for a header.
   logic [pkt_switch_pkg::num_ports-1:0] sel;
   logic                                 xfer_last;

   assign xfer_last = o_tready & i_tvalid & i_tlast;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         sel <= '0;
      end else if (sel == '0) begin
         // header seen, latch the route. nothing moves this cycle.
         if (i_tvalid) begin
            sel[i_tdata[pkt_switch_pkg::dest_bit]] <= 1'b1;
         end
      end else if (xfer_last) begin
         sel <= '0;
      end
   end

   // data and last go to every lane, valid only to the selected one.
   assign o_lane_tdata  = {pkt_switch_pkg::num_ports{i_tdata}};
   assign o_lane_tlast  = {pkt_switch_pkg::num_ports{i_tlast}};
   assign o_lane_tvalid = {pkt_switch_pkg::num_ports{i_tvalid}} & sel;

   assign o_tready = |(i_lane_tready & sel);

endmodule

//--- hw/stream_fifo.sv
// ========================================
// Synchronous FIFO with valid/ready on both sides.
// The payload type is set by the type parameter T.
// ========================================

`timescale 1ns/1ns

module stream_fifo #(
   parameter type T = pkt_switch_pkg::stream_word_t
) (
   input  logic clk,
   input  logic i_reset,
   input  T     i_data,
   input  logic i_valid,
   output logic o_ready,
   output T     o_data,
   output logic o_valid,
   input  logic i_ready
);

   T                          mem [pkt_switch_pkg::fifo_depth];
   pkt_switch_pkg::fifo_ptr_t wr_ptr;
   pkt_switch_pkg::fifo_ptr_t rd_ptr;
   pkt_switch_pkg::fifo_cnt_t count;
   logic                      wr_en;
   logic                      rd_en;

   assign o_ready = (count != pkt_switch_pkg::fifo_cnt_t'(pkt_switch_pkg::fifo_depth));
   assign o_valid = (count != '0);
   assign o_data  = mem[rd_ptr];

   assign wr_en = i_valid & o_ready;
   assign rd_en = o_valid & i_ready;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // pointers wrap at the last entry, so any depth works.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            if (wr_ptr == pkt_switch_pkg::fifo_ptr_t'(pkt_switch_pkg::fifo_depth - 1)) begin
               wr_ptr <= '0;
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (rd_en) begin
            if (rd_ptr == pkt_switch_pkg::fifo_ptr_t'(pkt_switch_pkg::fifo_depth - 1)) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- hw/pkt_switch_pkg.sv
// ========================================
// Shared constants and types for the 2x2 packet switch.
// Referenced by scoped names from every RTL block.
// ========================================

package pkt_switch_pkg;

   // stream word and port count.
   localparam int data_width = 16;
   localparam int num_ports  = 2;

   // header fields. dest_bit is only meaningful in the first word of a packet.
   localparam int dest_bit = 0;
   localparam int src_bit  = 1;
   localparam int seq_lsb  = 2;

   // output FIFO sizing.
   localparam int fifo_depth     = 4;
   localparam int fifo_ptr_width = $clog2(fifo_depth);
   localparam int fifo_cnt_width = $clog2(fifo_depth + 1);

   typedef logic [fifo_ptr_width-1:0] fifo_ptr_t;
   typedef logic [fifo_cnt_width-1:0] fifo_cnt_t;

   // one stream word with its end of packet flag.
   typedef struct packed {
      logic                  last;
      logic [data_width-1:0] data;
   } stream_word_t;

endpackage
